// File: src/rv_pkg.sv
package rv_pkg;

	// machine word and address width
	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0] reg_idx_t;

	// pc step between sequential instructions
	localparam word_t INSTR_BYTES = 'd4;

	// major opcodes of the supported subset
	localparam logic [6:0] OP_REG = 7'b0110011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL = 7'b1101111;

	// funct3 codes
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SRL = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	// only whole-word loads and stores
	localparam logic [2:0] F3_WORD = 3'b010;

	// funct7 codes
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB = 7'b0100000;

	// alu operations, pass_b serves lui and link gives pc plus four
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_PASS_B,
		ALU_LINK
	} alu_op_t;

endpackage

// File: src/fetch_unit.sv
module fetch_unit import rv_pkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input logic clk,
	input logic reset,
	input logic fetch_advance,
	input logic flush,
	input word_t redirect_target,
	output logic fetch_req,
	output word_t fetch_addr,
	input word_t instruction,
	input logic fetch_wait,
	output logic fd_valid,
	output word_t fd_pc,
	output word_t fd_instr
);

	// stays low through reset so no request goes out before the core runs
	logic fetch_on;
	word_t pc;
	logic fetch_done;

	assign fetch_addr = pc;
	// request whenever the fetch/decode register can take a new word
	assign fetch_req = fetch_on && fetch_advance;
	assign fetch_done = fetch_req && !fetch_wait;

	always_ff @(posedge clk) begin
		if (reset) begin
			fetch_on <= 1'b0;
			pc <= RESET_PC;
			fd_valid <= 1'b0;
		end else begin
			fetch_on <= 1'b1;
			if (flush) begin
				// redirect from a taken branch or jal
				pc <= redirect_target;
				fd_valid <= 1'b0;
			end else if (fetch_advance) begin
				// a pending wait hands decode a bubble
				fd_valid <= fetch_done;
				if (fetch_done) begin
					pc <= pc + INSTR_BYTES;
				end
			end
		end
	end

	// payload is only meaningful while fd_valid is set
	always_ff @(posedge clk) begin
		if (fetch_done) begin
			fd_pc <= pc;
			fd_instr <= instruction;
		end
	end

endmodule

// File: src/instr_decoder.sv
module instr_decoder import rv_pkg::*; (
	input logic clk,
	input logic reset,
	input logic decode_advance,
	input logic execute_advance,
	input logic flush,
	input logic fd_valid,
	input word_t fd_pc,
	input word_t fd_instr,
	output reg_idx_t rs1,
	output reg_idx_t rs2,
	output logic rs1_used,
	output logic rs2_used,
	input word_t rs1_data,
	input word_t rs2_data,
	output logic de_valid,
	output word_t de_pc,
	output word_t de_a,
	output word_t de_b,
	output word_t de_imm,
	output alu_op_t de_op,
	output reg_idx_t de_rd,
	output logic de_writes_rd,
	output logic de_is_load,
	output logic de_is_store,
	output logic de_is_branch,
	output logic de_branch_ne,
	output logic de_is_jal
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t imm_i, imm_s, imm_b, imm_u, imm_j;
	word_t imm;
	alu_op_t op;
	logic use_imm;
	logic writes, is_load, is_store, is_branch, is_jal;
	logic de_writes_q;

	// instruction fields
	assign opcode = fd_instr[6:0];
	assign funct3 = fd_instr[14:12];
	assign funct7 = fd_instr[31:25];
	assign rs1 = fd_instr[19:15];
	assign rs2 = fd_instr[24:20];

	// sign-extended immediates of each format
	assign imm_i = {{20{fd_instr[31]}}, fd_instr[31:20]};
	assign imm_s = {{20{fd_instr[31]}}, fd_instr[31:25], fd_instr[11:7]};
	assign imm_b = {{19{fd_instr[31]}}, fd_instr[31], fd_instr[7],
		fd_instr[30:25], fd_instr[11:8], 1'b0};
	assign imm_u = {fd_instr[31:12], 12'b0};
	assign imm_j = {{11{fd_instr[31]}}, fd_instr[31], fd_instr[19:12],
		fd_instr[20], fd_instr[30:21], 1'b0};

	always_comb begin
		// unknown encodings decode as a nop
		op = ALU_ADD;
		imm = imm_i;
		use_imm = 1'b0;
		writes = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		is_branch = 1'b0;
		is_jal = 1'b0;
		rs1_used = 1'b0;
		rs2_used = 1'b0;
		case (opcode)
			OP_REG: begin
				rs1_used = 1'b1;
				rs2_used = 1'b1;
				writes = 1'b1;
				case (funct3)
					F3_ADD_SUB: op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
					F3_SLL: op = ALU_SLL;
					F3_SLT: op = ALU_SLT;
					F3_XOR: op = ALU_XOR;
					F3_SRL: op = ALU_SRL;
					F3_OR: op = ALU_OR;
					F3_AND: op = ALU_AND;
					default: writes = 1'b0;
				endcase
				// sra and other funct7 variants are not supported
				if (funct7 != F7_BASE && funct7 != F7_SUB) begin
					writes = 1'b0;
				end
			end
			OP_IMM: begin
				// addi only
				rs1_used = 1'b1;
				use_imm = 1'b1;
				writes = (funct3 == F3_ADD_SUB);
			end
			OP_LUI: begin
				op = ALU_PASS_B;
				imm = imm_u;
				use_imm = 1'b1;
				writes = 1'b1;
			end
			OP_LOAD: begin
				rs1_used = 1'b1;
				use_imm = 1'b1;
				writes = (funct3 == F3_WORD);
				is_load = (funct3 == F3_WORD);
			end
			OP_STORE: begin
				// rs2 stays on de_b as store data
				rs1_used = 1'b1;
				rs2_used = 1'b1;
				imm = imm_s;
				is_store = (funct3 == F3_WORD);
			end
			OP_BRANCH: begin
				rs1_used = 1'b1;
				rs2_used = 1'b1;
				imm = imm_b;
				is_branch = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
			end
			OP_JAL: begin
				op = ALU_LINK;
				imm = imm_j;
				writes = 1'b1;
				is_jal = 1'b1;
			end
			default: begin
				writes = 1'b0;
			end
		endcase
	end

	// decode/execute valid, a stall leaves a bubble behind
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			de_valid <= 1'b0;
		end else if (decode_advance) begin
			de_valid <= fd_valid;
		end else if (execute_advance) begin
			de_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (decode_advance) begin
			de_pc <= fd_pc;
			de_a <= rs1_data;
			de_b <= use_imm ? imm : rs2_data;
			de_imm <= imm;
			de_op <= op;
			de_rd <= fd_instr[11:7];
			de_writes_q <= writes;
			de_is_load <= is_load;
			de_is_store <= is_store;
			de_is_branch <= is_branch;
			de_branch_ne <= (funct3 == F3_BNE);
			de_is_jal <= is_jal;
		end
	end

	// hazard detection sees only live writers
	assign de_writes_rd = de_valid && de_writes_q;

endmodule

// File: src/register_file.sv
module register_file import rv_pkg::*; (
	input logic clk,
	input reg_idx_t rs1,
	input reg_idx_t rs2,
	output word_t rs1_data,
	output word_t rs2_data,
	input logic wb_en,
	input reg_idx_t wb_rd,
	input word_t wb_data
);

	word_t regs [32];

	// x0 reads as zero whatever the array holds
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

	// writes to x0 are dropped
	always_ff @(posedge clk) begin
		if (wb_en && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

endmodule

// File: src/hazard_unit.sv
module hazard_unit import rv_pkg::*; (
	input logic fd_valid,
	input logic rs1_used,
	input logic rs2_used,
	input reg_idx_t rs1,
	input reg_idx_t rs2,
	input logic de_writes_rd,
	input logic em_writes_rd,
	input logic mw_writes_rd,
	input reg_idx_t de_rd,
	input reg_idx_t em_rd,
	input reg_idx_t mw_rd,
	input logic mem_busy,
	input logic branch_taken,
	output logic fetch_advance,
	output logic decode_advance,
	output logic execute_advance,
	output logic memory_advance,
	output logic flush
);

	logic rs1_hit;
	logic rs2_hit;
	logic stall;

	// any older instruction still in flight that will write src
	function automatic logic pending_write(input reg_idx_t src);
		return (de_writes_rd && de_rd == src)
			|| (em_writes_rd && em_rd == src)
			|| (mw_writes_rd && mw_rd == src);
	endfunction

	// no forwarding, so decode waits until the write has landed
	assign rs1_hit = rs1_used && rs1 != '0 && pending_write(rs1);
	assign rs2_hit = rs2_used && rs2 != '0 && pending_write(rs2);
	assign stall = fd_valid && (rs1_hit || rs2_hit);

	assign flush = branch_taken;

	// a data access in progress freezes the whole pipe
	assign memory_advance = !mem_busy;
	assign execute_advance = !mem_busy;
	// redirect wins over a stall, the stalled instruction is discarded anyway
	assign decode_advance = !mem_busy && (!stall || flush);
	// no fetch in the redirect cycle, its word would be dropped
	assign fetch_advance = decode_advance && !flush;

endmodule

// File: src/execute_stage.sv
module execute_stage import rv_pkg::*; (
	input logic clk,
	input logic reset,
	input logic execute_advance,
	input logic flush,
	input logic de_valid,
	input word_t de_pc,
	input word_t de_a,
	input word_t de_b,
	input word_t de_imm,
	input alu_op_t de_op,
	input reg_idx_t de_rd,
	input logic de_writes_rd,
	input logic de_is_load,
	input logic de_is_store,
	input logic de_is_branch,
	input logic de_branch_ne,
	input logic de_is_jal,
	output logic em_valid,
	output word_t em_result,
	output word_t em_store_data,
	output reg_idx_t em_rd,
	output logic em_writes_rd,
	output logic em_is_load,
	output logic em_is_store,
	output logic branch_taken,
	output word_t redirect_target
);

	word_t alu_b;
	word_t alu_result;
	logic operands_equal;
	logic taken;
	logic em_writes_q;
	logic em_taken_q;

	// stores keep rs2 on de_b, their address offset comes from the immediate
	assign alu_b = de_is_store ? de_imm : de_b;

	always_comb begin
		case (de_op)
			ALU_ADD: alu_result = de_a + alu_b;
			ALU_SUB: alu_result = de_a - alu_b;
			ALU_AND: alu_result = de_a & alu_b;
			ALU_OR: alu_result = de_a | alu_b;
			ALU_XOR: alu_result = de_a ^ alu_b;
			ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(de_a) < $signed(alu_b)};
			ALU_SLL: alu_result = de_a << alu_b[4:0];
			ALU_SRL: alu_result = de_a >> alu_b[4:0];
			ALU_PASS_B: alu_result = alu_b;
			ALU_LINK: alu_result = de_pc + INSTR_BYTES;
			default: alu_result = '0;
		endcase
	end

	// beq/bne compare, jal always redirects
	assign operands_equal = (de_a == de_b);
	assign taken = de_is_jal || (de_is_branch && (de_branch_ne ^ operands_equal));

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			em_valid <= 1'b0;
		end else if (execute_advance) begin
			em_valid <= de_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (execute_advance) begin
			em_result <= alu_result;
			em_store_data <= de_b;
			em_rd <= de_rd;
			em_writes_q <= de_writes_rd;
			em_is_load <= de_is_load;
			em_is_store <= de_is_store;
			em_taken_q <= taken;
			// branch and jal target
			redirect_target <= de_pc + de_imm;
		end
	end

	assign em_writes_rd = em_valid && em_writes_q;
	assign branch_taken = em_valid && em_taken_q;

	// the flush empties this register, so a redirect never repeats
	a_single_redirect: assert property (@(posedge clk) disable iff (reset)
		branch_taken |=> !branch_taken);

endmodule

// File: src/memory_stage.sv
module memory_stage import rv_pkg::*; (
	input logic clk,
	input logic reset,
	input logic memory_advance,
	input logic em_valid,
	input word_t em_result,
	input word_t em_store_data,
	input reg_idx_t em_rd,
	input logic em_writes_rd,
	input logic em_is_load,
	input logic em_is_store,
	output logic mem_read,
	output logic mem_write,
	output word_t mem_addr,
	output word_t mem_store_data,
	input word_t mem_load_data,
	input logic mem_wait,
	output logic mem_busy,
	output reg_idx_t mw_rd,
	output logic mw_writes_rd,
	output word_t wb_data
);

	// request stays up until the cycle mem_wait drops
	assign mem_read = em_valid && em_is_load;
	assign mem_write = em_valid && em_is_store;
	assign mem_addr = em_result;
	assign mem_store_data = em_store_data;
	assign mem_busy = (mem_read || mem_write) && mem_wait;

	// write-back register, mw_writes_rd is the register file enable
	always_ff @(posedge clk) begin
		if (reset) begin
			mw_writes_rd <= 1'b0;
		end else if (memory_advance) begin
			mw_writes_rd <= em_writes_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (memory_advance) begin
			mw_rd <= em_rd;
			// load data is only valid in the completing cycle
			wb_data <= em_is_load ? mem_load_data : em_result;
		end
	end

	a_rw_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(mem_read && mem_write));

	// upstream stages must hold the request while the memory waits
	a_request_hold: assert property (@(posedge clk) disable iff (reset)
		(mem_read || mem_write) && mem_wait |=>
		$stable(mem_read) && $stable(mem_write) && $stable(mem_addr)
		&& $stable(mem_store_data));

endmodule

// File: src/rv_core.sv
module rv_core import rv_pkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input logic clk,
	input logic reset,
	output logic fetch_req,
	output word_t fetch_addr,
	input word_t instruction,
	input logic fetch_wait,
	output logic mem_read,
	output logic mem_write,
	output word_t mem_addr,
	output word_t mem_store_data,
	input word_t mem_load_data,
	input logic mem_wait
);

	// stage enables and redirect
	logic fetch_advance, decode_advance, execute_advance, memory_advance, flush;
	logic branch_taken;
	word_t redirect_target;

	// fetch/decode
	logic fd_valid;
	word_t fd_pc, fd_instr;

	// decode sources
	reg_idx_t rs1, rs2;
	logic rs1_used, rs2_used;
	word_t rs1_data, rs2_data;

	// decode/execute
	logic de_valid;
	word_t de_pc, de_a, de_b, de_imm;
	alu_op_t de_op;
	reg_idx_t de_rd;
	logic de_writes_rd, de_is_load, de_is_store, de_is_branch, de_branch_ne, de_is_jal;

	// execute/memory
	logic em_valid;
	word_t em_result, em_store_data;
	reg_idx_t em_rd;
	logic em_writes_rd, em_is_load, em_is_store;

	// memory/write-back
	logic mem_busy;
	reg_idx_t mw_rd;
	logic mw_writes_rd;
	word_t wb_data;

	fetch_unit #(
		.RESET_PC(RESET_PC)
	) i_fetch_unit (
		.clk(clk), .reset(reset),
		.fetch_advance(fetch_advance), .flush(flush),
		.redirect_target(redirect_target),
		.fetch_req(fetch_req), .fetch_addr(fetch_addr),
		.instruction(instruction), .fetch_wait(fetch_wait),
		.fd_valid(fd_valid), .fd_pc(fd_pc), .fd_instr(fd_instr)
	);

	instr_decoder i_instr_decoder (
		.clk(clk), .reset(reset),
		.decode_advance(decode_advance), .execute_advance(execute_advance),
		.flush(flush),
		.fd_valid(fd_valid), .fd_pc(fd_pc), .fd_instr(fd_instr),
		.rs1(rs1), .rs2(rs2), .rs1_used(rs1_used), .rs2_used(rs2_used),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.de_valid(de_valid), .de_pc(de_pc), .de_a(de_a), .de_b(de_b),
		.de_imm(de_imm), .de_op(de_op), .de_rd(de_rd),
		.de_writes_rd(de_writes_rd), .de_is_load(de_is_load),
		.de_is_store(de_is_store), .de_is_branch(de_is_branch),
		.de_branch_ne(de_branch_ne), .de_is_jal(de_is_jal)
	);

	register_file i_register_file (
		.clk(clk),
		.rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.wb_en(mw_writes_rd), .wb_rd(mw_rd), .wb_data(wb_data)
	);

	hazard_unit i_hazard_unit (
		.fd_valid(fd_valid), .rs1_used(rs1_used), .rs2_used(rs2_used),
		.rs1(rs1), .rs2(rs2),
		.de_writes_rd(de_writes_rd), .em_writes_rd(em_writes_rd),
		.mw_writes_rd(mw_writes_rd),
		.de_rd(de_rd), .em_rd(em_rd), .mw_rd(mw_rd),
		.mem_busy(mem_busy), .branch_taken(branch_taken),
		.fetch_advance(fetch_advance), .decode_advance(decode_advance),
		.execute_advance(execute_advance), .memory_advance(memory_advance),
		.flush(flush)
	);

	execute_stage i_execute_stage (
		.clk(clk), .reset(reset),
		.execute_advance(execute_advance), .flush(flush),
		.de_valid(de_valid), .de_pc(de_pc), .de_a(de_a), .de_b(de_b),
		.de_imm(de_imm), .de_op(de_op), .de_rd(de_rd),
		.de_writes_rd(de_writes_rd), .de_is_load(de_is_load),
		.de_is_store(de_is_store), .de_is_branch(de_is_branch),
		.de_branch_ne(de_branch_ne), .de_is_jal(de_is_jal),
		.em_valid(em_valid), .em_result(em_result), .em_store_data(em_store_data),
		.em_rd(em_rd), .em_writes_rd(em_writes_rd),
		.em_is_load(em_is_load), .em_is_store(em_is_store),
		.branch_taken(branch_taken), .redirect_target(redirect_target)
	);

	memory_stage i_memory_stage (
		.clk(clk), .reset(reset),
		.memory_advance(memory_advance),
		.em_valid(em_valid), .em_result(em_result), .em_store_data(em_store_data),
		.em_rd(em_rd), .em_writes_rd(em_writes_rd),
		.em_is_load(em_is_load), .em_is_store(em_is_store),
		.mem_read(mem_read), .mem_write(mem_write),
		.mem_addr(mem_addr), .mem_store_data(mem_store_data),
		.mem_load_data(mem_load_data), .mem_wait(mem_wait),
		.mem_busy(mem_busy),
		.mw_rd(mw_rd), .mw_writes_rd(mw_writes_rd), .wb_data(wb_data)
	);

endmodule

// File: testbench/tb_clock.sv
module tb_clock #(
	parameter int PERIOD = 8,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// reset drops on a falling edge like every other input
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// File: testbench/tb_memory.sv
module tb_memory import rv_pkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input logic clk,
	input logic fetch_req,
	input word_t fetch_addr,
	output word_t instruction,
	output logic fetch_wait,
	input logic mem_read,
	input logic mem_write,
	input word_t mem_addr,
	input word_t mem_store_data,
	output word_t mem_load_data,
	output logic mem_wait,
	output logic store_done,
	output word_t store_addr,
	output word_t store_data
);
	timeunit 1ns;
	timeprecision 100ps;

	word_t rom [64];
	word_t ram [64];
	int load_word;

	// rv32i encoders for the hand-assembled program
	function automatic word_t r_type(input logic [6:0] f7, input int rs2, rs1,
		input logic [2:0] f3, input int rd);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_REG};
	endfunction

	function automatic word_t i_type(input int imm, rs1, input logic [2:0] f3,
		input int rd, input logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
	endfunction

	function automatic word_t s_type(input int imm, rs2, rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], F3_WORD, imm[4:0], OP_STORE};
	endfunction

	function automatic word_t b_type(input int imm, rs2, rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic word_t u_type(input int imm20, rd);
		return {imm20[19:0], rd[4:0], OP_LUI};
	endfunction

	function automatic word_t j_type(input int imm, rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
	endfunction

	task automatic put(input word_t w);
		rom[load_word[5:0]] = w;
		load_word++;
	endtask

	initial begin
		// unused rom words are addi x0 with the word index as immediate
		for (int j = 0; j < 64; j++) begin
			rom[j[5:0]] = i_type(j, 0, F3_ADD_SUB, 0, OP_IMM);
			ram[j[5:0]] = {16'hd0d0, 8'h00, j[5:0], 2'b00};
		end
		load_word = int'(RESET_PC[7:2]);
		// x1 base, x2 and x3 operands, x4 lui, x6 shift amount
		put(i_type(256, 0, F3_ADD_SUB, 1, OP_IMM));
		put(i_type(23, 0, F3_ADD_SUB, 2, OP_IMM));
		put(i_type(-5, 0, F3_ADD_SUB, 3, OP_IMM));
		put(u_type(32'h12345, 4));
		put(i_type(3, 0, F3_ADD_SUB, 6, OP_IMM));
		// one store per alu operation
		put(r_type(F7_BASE, 3, 2, F3_ADD_SUB, 5));
		put(s_type(0, 5, 1));
		put(r_type(F7_SUB, 3, 2, F3_ADD_SUB, 5));
		put(s_type(4, 5, 1));
		put(r_type(F7_BASE, 3, 2, F3_AND, 5));
		put(s_type(8, 5, 1));
		put(r_type(F7_BASE, 3, 2, F3_OR, 5));
		put(s_type(12, 5, 1));
		put(r_type(F7_BASE, 3, 2, F3_XOR, 5));
		put(s_type(16, 5, 1));
		put(r_type(F7_BASE, 2, 3, F3_SLT, 5));
		put(s_type(20, 5, 1));
		put(r_type(F7_BASE, 6, 2, F3_SLL, 5));
		put(s_type(24, 5, 1));
		put(r_type(F7_BASE, 6, 3, F3_SRL, 5));
		put(s_type(28, 5, 1));
		put(s_type(32, 4, 1));
		put(i_type(-100, 2, F3_ADD_SUB, 5, OP_IMM));
		put(s_type(36, 5, 1));
		// dependent chain on x7 with no gaps
		put(i_type(1, 0, F3_ADD_SUB, 7, OP_IMM));
		put(i_type(2, 7, F3_ADD_SUB, 7, OP_IMM));
		put(r_type(F7_BASE, 7, 7, F3_ADD_SUB, 7));
		put(i_type(5, 7, F3_ADD_SUB, 7, OP_IMM));
		put(s_type(40, 7, 1));
		// store, load back, store plus one
		put(i_type(1000, 0, F3_ADD_SUB, 8, OP_IMM));
		put(s_type(44, 8, 1));
		put(i_type(44, 1, F3_WORD, 9, OP_LOAD));
		put(i_type(1, 9, F3_ADD_SUB, 9, OP_IMM));
		put(s_type(48, 9, 1));
		// taken beq skips two stores
		put(b_type(12, 2, 2, F3_BEQ));
		put(s_type(52, 0, 1));
		put(s_type(56, 0, 1));
		// bne falls through to its store
		put(b_type(12, 2, 2, F3_BNE));
		put(s_type(60, 2, 1));
		// jal skips two stores and lands on the store of its link
		put(j_type(12, 10));
		put(s_type(68, 0, 1));
		put(s_type(72, 0, 1));
		put(s_type(64, 10, 1));
		put(j_type(0, 0));
	end

	// read data answers in the completing cycle
	always_comb begin
		if (fetch_req === 1'b1) begin
			instruction = rom[fetch_addr[7:2]];
		end else begin
			instruction = '0;
		end
		if (mem_read === 1'b1) begin
			mem_load_data = ram[mem_addr[7:2]];
		end else begin
			mem_load_data = '0;
		end
	end

	// one seed for the run and a fresh wait draw for both ports every falling edge
	initial begin
		fetch_wait = 1'b0;
		mem_wait = 1'b0;
		void'($urandom(66));
		forever begin
			@(negedge clk);
			fetch_wait <= ($urandom % 4) == 0;
			mem_wait <= ($urandom % 3) == 0;
		end
	end

	// store monitor
	assign store_done = mem_write && !mem_wait;
	assign store_addr = mem_addr;
	assign store_data = mem_store_data;

	always @(posedge clk) begin
		if (store_done === 1'b1) begin
			ram[mem_addr[7:2]] <= mem_store_data;
		end
	end

endmodule

// File: testbench/tb_top.sv
module tb_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] RESET_PC = 32'h40;
	localparam int RESET_CYCLES = 16;
	localparam int PROG_LEN = 44;
	// jal to itself is the last word of the program
	localparam logic [31:0] LOOP_PC = RESET_PC + 32'd172;
	localparam logic [31:0] BASE = 32'h100;

	logic clk, reset;
	logic fetch_req, fetch_wait, mem_read, mem_write, mem_wait;
	logic [31:0] fetch_addr, instruction, mem_addr, mem_store_data, mem_load_data;
	logic store_done;
	logic [31:0] store_addr, store_data;

	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	int exp_test [$];
	string names [6] = '{"reset_state", "alu_results", "raw_hazard", "load_store",
		"branch_flush", "store_order"};
	int fails [6] = '{0, 0, 0, 0, 0, 0};
	int store_idx = 0;
	int loop_hits = 0;
	int cycle = 0;
	logic first_seen = 1'b0;

	tb_clock #(.PERIOD(8), .RESET_CYCLES(RESET_CYCLES)) i_clock (.clk(clk), .reset(reset));

	tb_memory #(.RESET_PC(RESET_PC)) i_memory (
		.clk(clk), .fetch_req(fetch_req), .fetch_addr(fetch_addr),
		.instruction(instruction), .fetch_wait(fetch_wait),
		.mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
		.mem_store_data(mem_store_data), .mem_load_data(mem_load_data),
		.mem_wait(mem_wait), .store_done(store_done),
		.store_addr(store_addr), .store_data(store_data)
	);

	rv_core #(.RESET_PC(RESET_PC)) i_rv_core (
		.clk(clk), .reset(reset),
		.fetch_req(fetch_req), .fetch_addr(fetch_addr),
		.instruction(instruction), .fetch_wait(fetch_wait),
		.mem_read(mem_read), .mem_write(mem_write),
		.mem_addr(mem_addr), .mem_store_data(mem_store_data),
		.mem_load_data(mem_load_data), .mem_wait(mem_wait)
	);

	task automatic expect_store(input int test, input logic [31:0] offset, input logic [31:0] data);
		exp_test.push_back(test);
		exp_addr.push_back(BASE + offset);
		exp_data.push_back(data);
	endtask

	// expected stores from the rv32i definitions on the program constants
	initial begin
		logic [31:0] a;
		logic [31:0] b;
		a = 32'd23;
		b = -32'sd5;
		expect_store(1, 0, a + b);
		expect_store(1, 4, a - b);
		expect_store(1, 8, a & b);
		expect_store(1, 12, a | b);
		expect_store(1, 16, a ^ b);
		expect_store(1, 20, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
		expect_store(1, 24, a << 3);
		expect_store(1, 28, b >> 3);
		expect_store(1, 32, 32'h12345 << 12);
		expect_store(1, 36, a - 32'd100);
		expect_store(2, 40, (32'd1 + 32'd2) * 32'd2 + 32'd5);
		expect_store(3, 44, 32'd1000);
		expect_store(3, 48, 32'd1001);
		expect_store(4, 60, a);
		// link of the jal at word 39
		expect_store(4, 64, RESET_PC + 32'd156 + 32'd4);
	end

	always @(posedge clk) cycle <= cycle + 1;

	// the core registers are still unknown in the first cycle
	a_reset_quiet: assert property (@(posedge clk)
		reset && cycle > 0 |-> !fetch_req && !mem_read && !mem_write)
	else begin
		fails[0]++;
		$display("reset_state: a request was raised during reset");
	end

	a_mem_hold: assert property (@(posedge clk) disable iff (reset)
		(mem_read || mem_write) && mem_wait |=>
		$stable(mem_read) && $stable(mem_write) && $stable(mem_addr)
		&& $stable(mem_store_data))
	else begin
		fails[3]++;
		$display("load_store: data request changed while mem_wait was high");
	end

	always @(posedge clk) begin
		if (!reset && fetch_req && !first_seen) begin
			first_seen <= 1'b1;
			a_first_fetch: assert (fetch_addr == RESET_PC) else begin
				fails[0]++;
				$display("Fail reset_state expected %h actual %h", RESET_PC, fetch_addr);
			end
		end
		if (!reset && fetch_req && !fetch_wait && fetch_addr == LOOP_PC) begin
			loop_hits <= loop_hits + 1;
		end
		// ordered compare of every completed store
		if (!reset && store_done) begin
			if (store_idx >= exp_addr.size()) begin
				fails[5]++;
				$display("store_order: extra store of %h to %h", store_data, store_addr);
			end else begin
				a_store_match: assert (store_addr == exp_addr[store_idx]
					&& store_data == exp_data[store_idx]) else begin
					fails[exp_test[store_idx]]++;
					fails[5]++;
					$display("Fail %s expected %h@%h actual %h@%h",
						names[exp_test[store_idx]], exp_data[store_idx],
						exp_addr[store_idx], store_data, store_addr);
				end
			end
			store_idx <= store_idx + 1;
		end
	end

	initial begin
		int failed_tests;
		failed_tests = 0;
		wait (loop_hits >= 3);
		@(negedge clk);
		a_store_count: assert (store_idx == exp_addr.size()) else begin
			fails[5]++;
			$display("Fail store_order expected %0d actual %0d", exp_addr.size(), store_idx);
		end
		for (int t = 0; t < 6; t++) begin
			if (fails[t] == 0) begin
				$display("%s: pass", names[t]);
			end else begin
				$display("%s: %0d errors", names[t], fails[t]);
				failed_tests++;
			end
		end
		$display("tests: %0d passed, %0d failed", 6 - failed_tests, failed_tests);
		if (failed_tests == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// watchdog allows twenty cycles per program word after reset
	initial begin
		repeat (RESET_CYCLES + PROG_LEN * 20) @(posedge clk);
		$display("timeout: the core did not reach the final loop in time");
		$display("sim failed");
		$finish;
	end

endmodule

// File: all.f
src/rv_pkg.sv
src/fetch_unit.sv
src/instr_decoder.sv
src/register_file.sv
src/hazard_unit.sv
src/execute_stage.sv
src/memory_stage.sv
src/rv_core.sv
testbench/tb_clock.sv
testbench/tb_memory.sv
testbench/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_top
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG ?= sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
